//--- rtl/rename_pkg.sv
////////////////////////////////////////////////////////////
// rename core shared definitions
// sizes, opcode and state enums, packed structs passed
// between the rename, free list, ROB and retire blocks
////////////////////////////////////////////////////////////
package rename_pkg;

    // architectural and physical register files
    localparam int NUM_AR    = 32;
    localparam int AR_W      = 5;
    localparam int NUM_PR    = 64;
    localparam int PR_W      = 6;
    localparam int FL_DEPTH  = NUM_PR - NUM_AR; // regs not held by the arch map
    localparam int FL_W      = 5;
    localparam int ROB_DEPTH = 16;
    localparam int ROB_W     = 4;
    localparam int CNT_W     = 16;              // retired instruction counter

    typedef enum logic [1:0] {
        op_alu    = 2'd0,
        op_branch = 2'd1,
        op_halt   = 2'd2
    } op_e;

    typedef enum logic [1:0] {
        st_run     = 2'd0,
        st_recover = 2'd1,   // one cycle flush after a mispredict
        st_halted  = 2'd2
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////
    // packed structs

    typedef struct packed {
        logic            valid;
        logic            has_dest;
        logic [AR_W-1:0] dest_ar;
        op_e             op;
    } dispatch_req_t;

    typedef struct packed {
        logic [ROB_W-1:0] rob_idx;
        logic [PR_W-1:0]  new_pr;
        logic [PR_W-1:0]  old_pr;   // previous mapping of dest_ar
    } dispatch_rsp_t;

    typedef struct packed {
        logic             valid;
        logic [ROB_W-1:0] rob_idx;
        logic             mispredict;
    } complete_t;

    typedef struct packed {
        logic            valid;
        logic            done;
        logic            mispredict;
        logic            has_dest;
        op_e             op;
        logic [AR_W-1:0] ar;
        logic [PR_W-1:0] new_pr;
        logic [PR_W-1:0] old_pr;
    } rob_entry_t;

    typedef struct packed {
        logic            valid;
        logic            has_dest;
        op_e             op;
        logic [AR_W-1:0] ar;
        logic [PR_W-1:0] new_pr;
        logic [PR_W-1:0] old_pr;
    } retire_t;

endpackage

//--- rtl/free_list.sv
////////////////////////////////////////////////////////////
// physical register free list
// circular queue, pop at head, push at tail, rewind to full
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module free_list (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          pop,
    input  logic                          push,
    input  logic [rename_pkg::PR_W-1:0]   push_pr,
    input  logic                          rewind,
    output logic [rename_pkg::PR_W-1:0]   free_pr,
    output logic                          fl_empty
);

    logic [rename_pkg::PR_W-1:0] regs [rename_pkg::FL_DEPTH];
    logic [rename_pkg::FL_W-1:0] head;
    logic [rename_pkg::FL_W-1:0] tail;
    logic [rename_pkg::FL_W:0]   count;   // one extra bit to hold full

    assign free_pr  = regs[head];
    assign fl_empty = (count == '0);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            // regs above the arch range start free, in order
            for (int i = 0; i < rename_pkg::FL_DEPTH; i++) begin
                regs[i] <= rename_pkg::PR_W'(rename_pkg::NUM_AR + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (rename_pkg::FL_W+1)'(rename_pkg::FL_DEPTH);
        end else if (rewind) begin
            // tail minus FL_DEPTH wraps onto tail
            head  <= tail;
            count <= (rename_pkg::FL_W+1)'(rename_pkg::FL_DEPTH);
        end else begin
            if (push) begin
                regs[tail] <= push_pr;
                tail       <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + (rename_pkg::FL_W+1)'(push) - (rename_pkg::FL_W+1)'(pop);
        end
    end

endmodule

//--- rtl/rename_maps.sv
////////////////////////////////////////////////////////////
// register map tables
// speculative map written at dispatch, architectural map
// written at retire, restore copies arch into spec
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rename_maps (
    input  logic                          clock,
    input  logic                          arst_n,
    input  logic                          alloc_en,
    input  logic [rename_pkg::AR_W-1:0]   alloc_ar,
    input  logic [rename_pkg::PR_W-1:0]   alloc_pr,
    output logic [rename_pkg::PR_W-1:0]   old_pr,
    input  logic                          commit_en,
    input  logic [rename_pkg::AR_W-1:0]   commit_ar,
    input  logic [rename_pkg::PR_W-1:0]   commit_pr,
    input  logic                          restore
);

    logic [rename_pkg::PR_W-1:0] spec_map [rename_pkg::NUM_AR];
    logic [rename_pkg::PR_W-1:0] arch_map [rename_pkg::NUM_AR];

    assign old_pr = spec_map[alloc_ar];   // lookup before this cycle's write

    ////////////////////////////////////////////////////////////
    // architectural map
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
                arch_map[i] <= rename_pkg::PR_W'(i);   // identity
            end
        end else if (commit_en) begin
            arch_map[commit_ar] <= commit_pr;
        end
    end

    ////////////////////////////////////////////////////////////
    // speculative map
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
                spec_map[i] <= rename_pkg::PR_W'(i);
            end
        end else if (restore) begin
            for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
                spec_map[i] <= arch_map[i];
            end
            // fold in a commit landing in the same cycle
            if (commit_en) begin
                spec_map[commit_ar] <= commit_pr;
            end
        end else if (alloc_en) begin
            spec_map[alloc_ar] <= alloc_pr;
        end
    end

endmodule

//--- rtl/reorder_buffer.sv
////////////////////////////////////////////////////////////
// reorder buffer
// circular buffer of in flight instructions, completions
// in any order, head retires in program order
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module reorder_buffer (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic                           alloc_en,
    input  rename_pkg::rob_entry_t         alloc_entry,
    output logic [rename_pkg::ROB_W-1:0]   alloc_idx,
    input  rename_pkg::complete_t          complete,
    input  logic                           retire_en,
    output rename_pkg::rob_entry_t         head_entry,
    output logic                           rob_full,
    input  logic                           flush
);

    rename_pkg::rob_entry_t         entries [rename_pkg::ROB_DEPTH];
    logic [rename_pkg::ROB_W-1:0]   head;
    logic [rename_pkg::ROB_W-1:0]   tail;
    logic [rename_pkg::ROB_W:0]     count;
    logic                           complete_hit;

    assign alloc_idx  = tail;
    assign head_entry = entries[head];
    assign rob_full   = (count == (rename_pkg::ROB_W+1)'(rename_pkg::ROB_DEPTH));

    // stale completions to freed slots are dropped
    assign complete_hit = complete.valid & entries[complete.rob_idx].valid;

    ////////////////////////////////////////////////////////////
    // pointers
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en) begin
                tail <= tail + 1'b1;
            end
            if (retire_en) begin
                head <= head + 1'b1;
            end
            count <= count + (rename_pkg::ROB_W+1)'(alloc_en)
                           - (rename_pkg::ROB_W+1)'(retire_en);
        end
    end

    ////////////////////////////////////////////////////////////
    // entries, only the status bits are cleared
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].done  <= 1'b0;
            end
        end else if (flush) begin
            for (int i = 0; i < rename_pkg::ROB_DEPTH; i++) begin
                entries[i].valid <= 1'b0;   // wrong path squashed
            end
        end else begin
            if (alloc_en) begin
                entries[tail] <= alloc_entry;
            end
            if (complete_hit) begin
                entries[complete.rob_idx].done       <= 1'b1;
                entries[complete.rob_idx].mispredict <= complete.mispredict;
            end
            if (retire_en) begin
                entries[head].valid <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/retire_ctrl.sv
////////////////////////////////////////////////////////////
// retire controller
// run / recover / halted FSM, gates dispatch and retire,
// raises the one cycle flush and counts retirements
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module retire_ctrl (
    input  logic                           clock,
    input  logic                           arst_n,
    input  logic                           dispatch_valid,
    input  logic                           has_dest,
    input  logic                           rob_full,
    input  logic                           fl_empty,
    input  rename_pkg::rob_entry_t         head_entry,
    output logic                           dispatch_stall,
    output logic                           dispatch_fire,
    output logic                           retire_fire,
    output logic                           flush,
    output rename_pkg::ctrl_state_e        state,
    output logic [rename_pkg::CNT_W-1:0]   retire_count
);

    rename_pkg::ctrl_state_e state_nxt;
    logic                    retire_mispredict;
    logic                    retire_halt;

    // head may only leave while running
    assign retire_fire = (state == rename_pkg::st_run) & head_entry.valid & head_entry.done;

    assign retire_mispredict = retire_fire & head_entry.mispredict &
                               (head_entry.op == rename_pkg::op_branch);
    assign retire_halt       = retire_fire & (head_entry.op == rename_pkg::op_halt);

    // structural hazards plus any non run state
    assign dispatch_stall = rob_full | (fl_empty & has_dest) |
                            (state != rename_pkg::st_run);
    assign dispatch_fire  = dispatch_valid & ~dispatch_stall;

    assign flush = (state == rename_pkg::st_recover);

    ////////////////////////////////////////////////////////////
    // next state
    always_comb begin
        state_nxt = state;
        unique case (state)
            rename_pkg::st_run: begin
                if (retire_mispredict) begin
                    state_nxt = rename_pkg::st_recover;
                end else if (retire_halt) begin
                    state_nxt = rename_pkg::st_halted;
                end
            end
            rename_pkg::st_recover: state_nxt = rename_pkg::st_run; // flush done in one
            rename_pkg::st_halted:  state_nxt = rename_pkg::st_halted; // until reset
            default:                state_nxt = rename_pkg::st_run;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= rename_pkg::st_run;
            retire_count <= '0;
        end else begin
            state <= state_nxt;
            if (retire_fire) begin
                retire_count <= retire_count + 1'b1;
            end
        end
    end

endmodule

//--- rtl/rename_core.sv
////////////////////////////////////////////////////////////
// rename core top level
// single issue renaming with in order retirement, ties the
// retire controller, free list, map tables and ROB together
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rename_core (
    input  logic                           clock,
    input  logic                           arst_n,
    input  rename_pkg::dispatch_req_t      dispatch,
    input  rename_pkg::complete_t          complete,
    output logic                           dispatch_stall,
    output rename_pkg::dispatch_rsp_t      dispatch_rsp,
    output rename_pkg::retire_t            retire,
    output logic                           recover,
    output logic                           halted,
    output logic [rename_pkg::CNT_W-1:0]   retire_count
);

    logic                            dispatch_fire;
    logic                            retire_fire;
    logic                            flush;
    rename_pkg::ctrl_state_e         state;
    logic                            rob_full;
    logic                            fl_empty;
    logic [rename_pkg::PR_W-1:0]     free_pr;
    logic [rename_pkg::PR_W-1:0]     old_pr;
    logic [rename_pkg::ROB_W-1:0]    alloc_idx;
    rename_pkg::rob_entry_t          head_entry;
    rename_pkg::rob_entry_t          alloc_entry;
    logic                            alloc_pr_en;   // dispatch that takes a free reg
    logic                            commit_en;     // retire that frees old_pr

    assign alloc_pr_en = dispatch_fire & dispatch.has_dest;
    assign commit_en   = retire_fire & head_entry.has_dest;

    ////////////////////////////////////////////////////////////
    // entry written into the ROB tail
    assign alloc_entry.valid      = 1'b1;
    assign alloc_entry.done       = 1'b0;
    assign alloc_entry.mispredict = 1'b0;
    assign alloc_entry.has_dest   = dispatch.has_dest;
    assign alloc_entry.op         = dispatch.op;
    assign alloc_entry.ar         = dispatch.dest_ar;
    assign alloc_entry.new_pr     = free_pr;
    assign alloc_entry.old_pr     = old_pr;

    assign dispatch_rsp.rob_idx = alloc_idx;
    assign dispatch_rsp.new_pr  = free_pr;
    assign dispatch_rsp.old_pr  = old_pr;

    // retiring head
    assign retire.valid    = retire_fire;
    assign retire.has_dest = head_entry.has_dest;
    assign retire.op       = head_entry.op;
    assign retire.ar       = head_entry.ar;
    assign retire.new_pr   = head_entry.new_pr;
    assign retire.old_pr   = head_entry.old_pr;

    assign recover = flush;
    assign halted  = (state == rename_pkg::st_halted);

    retire_ctrl u_ctrl (
        .clock          (clock),
        .arst_n         (arst_n),
        .dispatch_valid (dispatch.valid),
        .has_dest       (dispatch.has_dest),
        .rob_full       (rob_full),
        .fl_empty       (fl_empty),
        .head_entry     (head_entry),
        .dispatch_stall (dispatch_stall),
        .dispatch_fire  (dispatch_fire),
        .retire_fire    (retire_fire),
        .flush          (flush),
        .state          (state),
        .retire_count   (retire_count)
    );

    free_list u_fl (
        .clock    (clock),
        .arst_n   (arst_n),
        .pop      (alloc_pr_en),
        .push     (commit_en),
        .push_pr  (head_entry.old_pr),   // superseded mapping goes back
        .rewind   (flush),
        .free_pr  (free_pr),
        .fl_empty (fl_empty)
    );

    rename_maps u_maps (
        .clock     (clock),
        .arst_n    (arst_n),
        .alloc_en  (alloc_pr_en),
        .alloc_ar  (dispatch.dest_ar),
        .alloc_pr  (free_pr),
        .old_pr    (old_pr),
        .commit_en (commit_en),
        .commit_ar (head_entry.ar),
        .commit_pr (head_entry.new_pr),
        .restore   (flush)
    );

    reorder_buffer u_rob (
        .clock       (clock),
        .arst_n      (arst_n),
        .alloc_en    (dispatch_fire),
        .alloc_entry (alloc_entry),
        .alloc_idx   (alloc_idx),
        .complete    (complete),
        .retire_en   (retire_fire),
        .head_entry  (head_entry),
        .rob_full    (rob_full),
        .flush       (flush)
    );

endmodule

//--- dv/rename_core_properties.sv
////////////////////////////////////////////////////////////
// rename core protocol properties
// recover pulse, mispredict to recover, halt stickiness
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module rename_core_properties (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 recover,
    input  logic                 halted,
    input  logic                 dispatch_stall,
    input  rename_pkg::retire_t  retire,
    input  logic                 head_mispredict
);

    int unsigned fail_count = 0;   // failed assertions so far
    logic        misp_retire;

    // a branch leaving the ROB with a bad prediction
    assign misp_retire = retire.valid & head_mispredict &
                         (retire.op == rename_pkg::op_branch);

    ////////////////////////////////////////////////////////////
    // recovery
    recover_one_cycle: assert property (@(posedge clock) disable iff (!arst_n)
        recover |=> !recover)
        else begin $error("recover stayed high for more than one cycle"); fail_count++; end

    misp_then_recover: assert property (@(posedge clock) disable iff (!arst_n)
        misp_retire |=> recover)
        else begin $error("no recover after a mispredicted branch retired"); fail_count++; end

    recover_has_cause: assert property (@(posedge clock) disable iff (!arst_n)
        recover |-> $past(misp_retire))
        else begin $error("recover without a mispredicted retire before it"); fail_count++; end

    recover_stalls: assert property (@(posedge clock) disable iff (!arst_n)
        recover |-> dispatch_stall)
        else begin $error("dispatch was open during recover"); fail_count++; end

    ////////////////////////////////////////////////////////////
    // halt
    halted_sticky: assert property (@(posedge clock) disable iff (!arst_n)
        halted |=> halted)
        else begin $error("halted dropped before reset"); fail_count++; end

    halted_quiet: assert property (@(posedge clock) disable iff (!arst_n)
        halted |-> (dispatch_stall && !retire.valid))
        else begin $error("dispatch open or retire seen while halted"); fail_count++; end

endmodule

bind rename_core rename_core_properties u_props (
    .clock           (clock),
    .arst_n          (arst_n),
    .recover         (recover),
    .halted          (halted),
    .dispatch_stall  (dispatch_stall),
    .retire          (retire),
    .head_mispredict (head_entry.mispredict)   // internal head of the ROB
);

//--- dv/tb_rename_core.sv
////////////////////////////////////////////////////////////
// rename core testbench
// lfsr driven dispatch and completion, checked against a
// model of the free list, both maps and in flight queue
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_rename_core;

    localparam int RESET_CYC = 8;
    localparam int PLAN_CYC  = RESET_CYC + 3 + 60 + 120 + 24 + 30 + 120 + 40 + 20;

    typedef struct packed {
        logic [rename_pkg::ROB_W-1:0] rob_idx;
        logic                         has_dest;
        rename_pkg::op_e              op;
        logic [rename_pkg::AR_W-1:0]  ar;
        logic [rename_pkg::PR_W-1:0]  new_pr;
        logic [rename_pkg::PR_W-1:0]  old_pr;
        logic                         done;
        logic                         misp;
    } flight_t;

    logic                          clock;
    logic                          arst_n;
    rename_pkg::dispatch_req_t     dispatch;
    rename_pkg::complete_t         complete;
    logic                          dispatch_stall;
    rename_pkg::dispatch_rsp_t     dispatch_rsp;
    rename_pkg::retire_t           retire;
    logic                          recover;
    logic                          halted;
    logic [rename_pkg::CNT_W-1:0]  retire_count;

    ////////////////////////////////////////////////////////////
    // reference model state
    flight_t                       flight_q [$];   // oldest at front
    logic [rename_pkg::PR_W-1:0]   fl_q [$];
    logic [rename_pkg::PR_W-1:0]   spec_m [rename_pkg::NUM_AR];
    logic [rename_pkg::PR_W-1:0]   arch_m [rename_pkg::NUM_AR];
    rename_pkg::ctrl_state_e       m_state;
    int unsigned                   m_count;
    logic [rename_pkg::ROB_W-1:0]  m_tail;

    // stimulus knobs
    logic [15:0]                   lfsr;
    logic                          want_disp;
    logic                          want_comp;
    logic                          mixed_ops;       // branches among the alu ops
    logic                          allow_misp;
    logic                          halt_next;
    logic                          pending;         // held request after a stall
    int                            ar_mask;
    int                            comp_pos;
    int                            errors;
    int                            prop_errors;

    rename_core u_dut (
        .clock          (clock),
        .arst_n         (arst_n),
        .dispatch       (dispatch),
        .complete       (complete),
        .dispatch_stall (dispatch_stall),
        .dispatch_rsp   (dispatch_rsp),
        .retire         (retire),
        .recover        (recover),
        .halted         (halted),
        .retire_count   (retire_count)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial begin
        #(PLAN_CYC * 4 * 2);
        $display("watchdog expired, the tests did not finish in %0d ns", PLAN_CYC * 8);
        $display("TEST FAIL");
        $finish;
    end

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);   // one step per bit
        end
    endtask

    task automatic check_val(input string name, input int exp, input int got);
        assert (exp == got) else begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic reset_model();
        fl_q.delete();
        flight_q.delete();
        for (int i = 0; i < rename_pkg::FL_DEPTH; i++) begin
            fl_q.push_back(rename_pkg::PR_W'(rename_pkg::NUM_AR + i));
        end
        for (int i = 0; i < rename_pkg::NUM_AR; i++) begin
            spec_m[i] = rename_pkg::PR_W'(i);
            arch_m[i] = rename_pkg::PR_W'(i);
        end
        m_state = rename_pkg::st_run;
        m_count = 0;
        m_tail  = '0;
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus, called just after the falling edge
    task automatic drive_inputs();
        int v;
        int open_pos [$];
        complete = '0;
        comp_pos = -1;
        if (!pending) begin
            dispatch = '0;
            if (want_disp) begin
                dispatch.valid = 1'b1;
                if (halt_next) begin
                    dispatch.op = rename_pkg::op_halt;
                    halt_next   = 1'b0;
                end else begin
                    take_bits(2, v);
                    if (mixed_ops && v == 0) begin
                        dispatch.op = rename_pkg::op_branch;   // no dest
                    end else begin
                        dispatch.op       = rename_pkg::op_alu;
                        dispatch.has_dest = 1'b1;
                    end
                end
                take_bits(5, v);
                dispatch.dest_ar = rename_pkg::AR_W'(v & ar_mask);
            end
        end
        if (want_comp && m_state != rename_pkg::st_recover) begin
            foreach (flight_q[i]) begin
                if (!flight_q[i].done) open_pos.push_back(i);
            end
            if (open_pos.size() > 0) begin
                take_bits(4, v);
                comp_pos         = open_pos[v % open_pos.size()];   // shuffled order
                complete.valid   = 1'b1;
                complete.rob_idx = flight_q[comp_pos].rob_idx;
                if (allow_misp && flight_q[comp_pos].op == rename_pkg::op_branch) begin
                    take_bits(1, v);
                    complete.mispredict = v[0];
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // compare outputs, then advance the model by one clock
    task automatic check_and_update();
        logic    exp_retire;
        logic    exp_stall;
        logic    fire;
        flight_t head;
        flight_t entry;
        exp_retire = 1'b0;
        if (m_state == rename_pkg::st_run && flight_q.size() > 0) begin
            exp_retire = flight_q[0].done;
        end
        exp_stall = (flight_q.size() == rename_pkg::ROB_DEPTH) ||
                    (fl_q.size() == 0 && dispatch.has_dest) ||
                    (m_state != rename_pkg::st_run);
        fire = dispatch.valid && !exp_stall;
        check_val("dispatch_stall", int'(exp_stall), int'(dispatch_stall));
        check_val("retire.valid", int'(exp_retire), int'(retire.valid));
        check_val("recover", int'(m_state == rename_pkg::st_recover), int'(recover));
        check_val("halted", int'(m_state == rename_pkg::st_halted), int'(halted));
        check_val("retire_count", int'(m_count), int'(retire_count));
        if (exp_retire) begin
            check_val("retire.has_dest", int'(flight_q[0].has_dest), int'(retire.has_dest));
            check_val("retire.op", int'(flight_q[0].op), int'(retire.op));
            if (flight_q[0].has_dest) begin
                check_val("retire.ar", int'(flight_q[0].ar), int'(retire.ar));
                check_val("retire.new_pr", int'(flight_q[0].new_pr), int'(retire.new_pr));
                check_val("retire.old_pr", int'(flight_q[0].old_pr), int'(retire.old_pr));
            end
        end
        if (fire) begin
            check_val("dispatch_rsp.rob_idx", int'(m_tail), int'(dispatch_rsp.rob_idx));
            if (dispatch.has_dest) begin
                check_val("dispatch_rsp.new_pr", int'(fl_q[0]), int'(dispatch_rsp.new_pr));
                check_val("dispatch_rsp.old_pr", int'(spec_m[dispatch.dest_ar]),
                          int'(dispatch_rsp.old_pr));
            end
        end
        pending = dispatch.valid && !fire;
        if (m_state == rename_pkg::st_recover) begin
            // squashed allocations go back to the list front, oldest first
            for (int i = flight_q.size() - 1; i >= 0; i--) begin
                if (flight_q[i].has_dest) fl_q.push_front(flight_q[i].new_pr);
                if (flight_q[i].op == rename_pkg::op_halt) halt_next = 1'b1;   // sent again
            end
            spec_m  = arch_m;
            flight_q.delete();
            m_tail  = '0;
            m_state = rename_pkg::st_run;
        end else begin
            if (comp_pos >= 0) begin
                flight_q[comp_pos].done = 1'b1;
                flight_q[comp_pos].misp = complete.mispredict;
            end
            if (exp_retire) begin
                head = flight_q.pop_front();
                m_count++;
                if (head.has_dest) begin
                    fl_q.push_back(head.old_pr);   // superseded reg freed
                    arch_m[head.ar] = head.new_pr;
                end
                if (head.op == rename_pkg::op_branch && head.misp) begin
                    m_state = rename_pkg::st_recover;
                end else if (head.op == rename_pkg::op_halt) begin
                    m_state = rename_pkg::st_halted;
                end
            end
            if (fire) begin
                entry          = '0;
                entry.rob_idx  = m_tail;
                entry.has_dest = dispatch.has_dest;
                entry.op       = dispatch.op;
                entry.ar       = dispatch.dest_ar;
                entry.old_pr   = spec_m[dispatch.dest_ar];
                if (dispatch.has_dest) begin
                    entry.new_pr = fl_q.pop_front();
                    spec_m[dispatch.dest_ar] = entry.new_pr;
                end
                flight_q.push_back(entry);
                m_tail++;
            end
        end
    endtask

    task automatic run_cycles(input int n);
        repeat (n) begin
            @(negedge clock);
            drive_inputs();
            #1;   // combinational outputs settled
            check_and_update();
        end
    endtask

    initial begin
        dispatch   = '0;
        complete   = '0;
        arst_n     = 1'b0;
        lfsr       = 16'd49773;
        want_disp  = 1'b0;
        want_comp  = 1'b0;
        mixed_ops  = 1'b0;
        allow_misp = 1'b0;
        halt_next  = 1'b0;
        pending    = 1'b0;
        ar_mask    = 31;
        comp_pos   = -1;
        errors     = 0;
        reset_model();
        repeat (RESET_CYC) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        run_cycles(3);                          // idle after reset
        want_disp = 1'b1;
        want_comp = 1'b1;
        ar_mask   = 7;
        run_cycles(60);                         // rename chains, list recycling
        mixed_ops = 1'b1;
        ar_mask   = 31;
        run_cycles(120);                        // out of order completion
        mixed_ops = 1'b0;
        want_comp = 1'b0;
        run_cycles(24);                         // fill the ROB
        want_comp = 1'b1;
        run_cycles(30);
        mixed_ops  = 1'b1;
        allow_misp = 1'b1;
        run_cycles(120);                        // mispredict recovery
        mixed_ops  = 1'b0;
        allow_misp = 1'b0;
        halt_next  = 1'b1;
        while (!halted) run_cycles(1);
        run_cycles(20);                         // completions after halt
        prop_errors = int'(u_dut.u_props.fail_count);
        $display("done: %0d value errors, %0d property errors", errors, prop_errors);
        if (errors == 0 && prop_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
rtl/rename_pkg.sv
rtl/free_list.sv
rtl/rename_maps.sv
rtl/reorder_buffer.sv
rtl/retire_ctrl.sv
rtl/rename_core.sv
dv/rename_core_properties.sv
dv/tb_rename_core.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the rename core testbench with Verilator
# exit status is 0 only when the pass line appears

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_rename_core -f vlog.f \
    && ./obj_dir/Vtb_rename_core +verilator+error+limit+1000 \
    | tee /dev/stderr | grep -qx "TEST PASS" \
    && exit 0 || exit 1
